// File: common/sniff_params.svh
/*
 * Widths and limits shared by the CCI-P request checker.
 * Addresses are cache-line addresses, not byte addresses.
 * SNIFF_TIMER_WIDTH must hold SNIFF_MMIO_TIMEOUT.
 */

`ifndef SNIFF_PARAMS_SVH
`define SNIFF_PARAMS_SVH

// Cache-line address and request tag
`define SNIFF_ADDR_WIDTH    42
`define SNIFF_MDATA_WIDTH   16

// MMIO transaction ID, one tracker entry per value
`define SNIFF_TID_WIDTH     9

// Cycles an MMIO read may stay unanswered
`define SNIFF_MMIO_TIMEOUT  512
`define SNIFF_TIMER_WIDTH   10

`endif

// File: common/ccip_hdr_pkg.sv
/*
 * CCI-P request encodings and request header layouts.
 * Request types follow the single shared CCI-P encoding.
 * Data fields and response headers are not modeled.
 */

`include "sniff_params.svh"

package ccip_hdr_pkg;

   // Request types of C0 and C1 in one encoding
   typedef enum logic [3:0] {
      REQ_WRLINE_I = 4'h1,
      REQ_WRLINE_M = 4'h2,
      REQ_RDLINE_S = 4'h4,
      REQ_WRFENCE  = 4'h5,
      REQ_RDLINE_I = 4'h6
   } req_type_e;

   // Burst length in cache lines, three is illegal
   typedef enum logic [1:0] {
      CL_LEN_1 = 2'b00,
      CL_LEN_2 = 2'b01,
      CL_LEN_3 = 2'b10,
      CL_LEN_4 = 2'b11
   } cl_len_e;

   // Virtual channel select
   typedef enum logic [1:0] {
      VC_VA  = 2'b00,
      VC_VL0 = 2'b01,
      VC_VH0 = 2'b10,
      VC_VH1 = 2'b11
   } vc_e;

   // Read request header on C0 Tx
   typedef struct packed {
      vc_e                            vc;
      cl_len_e                        cl_len;
      req_type_e                      req_type;
      logic [`SNIFF_ADDR_WIDTH-1:0]   address;
      logic [`SNIFF_MDATA_WIDTH-1:0]  mdata;
   } c0_req_hdr_t;

   // Write request header on C1 Tx, sop marks a first beat
   typedef struct packed {
      vc_e                            vc;
      logic                           sop;
      cl_len_e                        cl_len;
      req_type_e                      req_type;
      logic [`SNIFF_ADDR_WIDTH-1:0]   address;
      logic [`SNIFF_MDATA_WIDTH-1:0]  mdata;
   } c1_req_hdr_t;

   // MMIO view of the C0 Rx header
   typedef struct packed {
      logic [15:0]                    address;
      logic [1:0]                     length;
      logic                           rsvd;
      logic [`SNIFF_TID_WIDTH-1:0]    tid;
   } mmio_req_hdr_t;

endpackage

// File: common/sniff_pkg.sv
/*
 * Error vector layout and write-burst states of the checker.
 * Bit positions of err follow the order of err_idx_e.
 */

package sniff_pkg;

   localparam int ERR_COUNT = 14;

   // One bit per rule, WARN bits are advisory only
   typedef enum logic [3:0] {
      ERR_C0_TYPE          = 4'd0,
      ERR_C1_TYPE          = 4'd1,
      ERR_C0_LEN3          = 4'd2,
      ERR_C0_ALIGN         = 4'd3,
      ERR_C1_LEN3          = 4'd4,
      ERR_C1_ALIGN         = 4'd5,
      ERR_C1_SOP           = 4'd6,
      ERR_C1_ADDR          = 4'd7,
      ERR_C1_VC            = 4'd8,
      WARN_C1_MDATA        = 4'd9,
      WARN_C0_OVERFLOW     = 4'd10,
      WARN_C1_OVERFLOW     = 4'd11,
      ERR_MMIO_UNSOLICITED = 4'd12,
      ERR_MMIO_TIMEOUT     = 4'd13
   } err_idx_e;

   typedef logic [ERR_COUNT-1:0] err_vec_t;

   // Encoding doubles as the line offset of the expected beat
   typedef enum logic [1:0] {
      WR_IDLE  = 2'd0,
      WR_BEAT2 = 2'd1,
      WR_BEAT3 = 2'd2,
      WR_BEAT4 = 2'd3
   } wr_burst_e;

endpackage

// File: verilog/tx_request_check.sv
/*
 * Single-request rules on C0 and C1 Tx.
 * C0 length and alignment rules apply to every valid read.
 * C1 length and alignment live in the write burst checker.
 */

`include "sniff_params.svh"

module tx_request_check (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       c0_tx_valid,
   input  ccip_hdr_pkg::c0_req_hdr_t  c0_tx_hdr,
   input  logic                       c0_tx_full,
   input  logic                       c1_tx_valid,
   input  ccip_hdr_pkg::c1_req_hdr_t  c1_tx_hdr,
   input  logic                       c1_tx_full,
   output sniff_pkg::err_vec_t        err
);

   sniff_pkg::err_vec_t err_next;
   logic                c0_type_ok;
   logic                c1_type_ok;

   // Reads only on C0
   assign c0_type_ok = (c0_tx_hdr.req_type == ccip_hdr_pkg::REQ_RDLINE_I) ||
                       (c0_tx_hdr.req_type == ccip_hdr_pkg::REQ_RDLINE_S);

   // Writes and fence only on C1
   assign c1_type_ok = (c1_tx_hdr.req_type == ccip_hdr_pkg::REQ_WRLINE_I) ||
                       (c1_tx_hdr.req_type == ccip_hdr_pkg::REQ_WRLINE_M) ||
                       (c1_tx_hdr.req_type == ccip_hdr_pkg::REQ_WRFENCE);

   always_comb begin
      err_next = '0;
      if (c0_tx_valid) begin
         err_next[sniff_pkg::ERR_C0_TYPE] = !c0_type_ok;
         err_next[sniff_pkg::ERR_C0_LEN3] = (c0_tx_hdr.cl_len == ccip_hdr_pkg::CL_LEN_3);
         // 2-line needs even address, 4-line a multiple of four
         if (c0_tx_hdr.cl_len == ccip_hdr_pkg::CL_LEN_2) begin
            err_next[sniff_pkg::ERR_C0_ALIGN] = c0_tx_hdr.address[0];
         end else if (c0_tx_hdr.cl_len == ccip_hdr_pkg::CL_LEN_4) begin
            err_next[sniff_pkg::ERR_C0_ALIGN] = |c0_tx_hdr.address[1:0];
         end
         // Pushed against a full port
         err_next[sniff_pkg::WARN_C0_OVERFLOW] = c0_tx_full;
      end
      if (c1_tx_valid) begin
         err_next[sniff_pkg::ERR_C1_TYPE]      = !c1_type_ok;
         err_next[sniff_pkg::WARN_C1_OVERFLOW] = c1_tx_full;
      end
   end

   // One-cycle registered pulses
   always_ff @(posedge clk) begin
      if (reset) begin
         err <= '0;
      end else begin
         err <= err_next;
      end
   end

endmodule

// File: mcl_write/mcl_write_check.sv
/*
 * Multi-cacheline write burst tracker on C1 Tx.
 * Only WrLine requests count as beats, a WrFence mid-burst is ignored.
 * A burst that starts misaligned is still tracked to its end.
 * Beats after the first are checked against the first beat's header.
 */

`include "sniff_params.svh"

module mcl_write_check (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       c1_tx_valid,
   input  ccip_hdr_pkg::c1_req_hdr_t  c1_tx_hdr,
   output sniff_pkg::err_vec_t        err
);

   localparam int ADDR_W  = `SNIFF_ADDR_WIDTH;
   localparam int MDATA_W = `SNIFF_MDATA_WIDTH;

   sniff_pkg::wr_burst_e   state;
   sniff_pkg::wr_burst_e   state_next;
   logic [ADDR_W-1:0]      base_addr;
   ccip_hdr_pkg::cl_len_e  burst_len;
   ccip_hdr_pkg::vc_e      burst_vc;
   logic [MDATA_W-1:0]     burst_mdata;
   logic                   beat;
   logic                   first_beat;
   logic [ADDR_W-1:0]      exp_addr;
   sniff_pkg::err_vec_t    err_next;

   assign beat = c1_tx_valid &&
                 ((c1_tx_hdr.req_type == ccip_hdr_pkg::REQ_WRLINE_I) ||
                  (c1_tx_hdr.req_type == ccip_hdr_pkg::REQ_WRLINE_M));

   assign first_beat = beat && (state == sniff_pkg::WR_IDLE);

   // State encoding is the line offset from the base
   assign exp_addr = base_addr + ADDR_W'(state);

   always_comb begin
      state_next = state;
      err_next   = '0;
      if (first_beat) begin
         err_next[sniff_pkg::ERR_C1_SOP] = !c1_tx_hdr.sop;
         case (c1_tx_hdr.cl_len)
            ccip_hdr_pkg::CL_LEN_2: begin
               err_next[sniff_pkg::ERR_C1_ALIGN] = c1_tx_hdr.address[0];
               state_next = sniff_pkg::WR_BEAT2;
            end
            ccip_hdr_pkg::CL_LEN_3: begin
               // Illegal length, no burst follows
               err_next[sniff_pkg::ERR_C1_LEN3] = 1'b1;
            end
            ccip_hdr_pkg::CL_LEN_4: begin
               err_next[sniff_pkg::ERR_C1_ALIGN] = |c1_tx_hdr.address[1:0];
               state_next = sniff_pkg::WR_BEAT2;
            end
            default: begin
               state_next = sniff_pkg::WR_IDLE;
            end
         endcase
      end else if (beat) begin
         // Follow-on beat of an open burst
         err_next[sniff_pkg::ERR_C1_SOP]    = c1_tx_hdr.sop;
         err_next[sniff_pkg::ERR_C1_ADDR]   = (c1_tx_hdr.address != exp_addr);
         err_next[sniff_pkg::ERR_C1_VC]     = (c1_tx_hdr.vc != burst_vc);
         // First beat's mdata is the one used, change only warned
         err_next[sniff_pkg::WARN_C1_MDATA] = (c1_tx_hdr.mdata != burst_mdata);
         case (state)
            sniff_pkg::WR_BEAT2: begin
               if (burst_len == ccip_hdr_pkg::CL_LEN_2) begin
                  state_next = sniff_pkg::WR_IDLE;
               end else begin
                  state_next = sniff_pkg::WR_BEAT3;
               end
            end
            sniff_pkg::WR_BEAT3: state_next = sniff_pkg::WR_BEAT4;
            default:             state_next = sniff_pkg::WR_IDLE;
         endcase
      end
   end

   // First beat header, reference for the rest of the burst
   always_ff @(posedge clk) begin
      if (first_beat) begin
         base_addr   <= c1_tx_hdr.address;
         burst_len   <= c1_tx_hdr.cl_len;
         burst_vc    <= c1_tx_hdr.vc;
         burst_mdata <= c1_tx_hdr.mdata;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= sniff_pkg::WR_IDLE;
         err   <= '0;
      end else begin
         state <= state_next;
         err   <= err_next;
      end
   end

endmodule

// File: mmio_tracker/mmio_tracker.sv
/*
 * MMIO read tracker, one entry per TID.
 * Timeout fires once per request, SNIFF_MMIO_TIMEOUT cycles after it.
 * A response sampled on the timeout edge still counts as in time.
 * A request and a response in the same cycle leave the TID active.
 */

`include "sniff_params.svh"

module mmio_tracker (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          c0_rx_mmio_rd_valid,
   input  ccip_hdr_pkg::mmio_req_hdr_t   c0_rx_hdr,
   input  logic                          c2_tx_mmio_rd_valid,
   input  logic [`SNIFF_TID_WIDTH-1:0]   c2_tx_tid,
   output sniff_pkg::err_vec_t           err
);

   localparam int TID_W   = `SNIFF_TID_WIDTH;
   localparam int DEPTH   = 2 ** TID_W;
   localparam int TIMER_W = `SNIFF_TIMER_WIDTH;
   // Timer value seen on the edge that must raise the pulse
   localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(`SNIFF_MMIO_TIMEOUT - 1);

   logic [DEPTH-1:0]    active_vec;
   logic [DEPTH-1:0]    expire_vec;
   sniff_pkg::err_vec_t err_next;

   for (genvar i = 0; i < DEPTH; i++) begin : g_tid
      logic               req_hit;
      logic               rsp_hit;
      logic               active;
      logic               fired;
      logic [TIMER_W-1:0] timer;

      assign req_hit = c0_rx_mmio_rd_valid && (c0_rx_hdr.tid == TID_W'(i));
      assign rsp_hit = c2_tx_mmio_rd_valid && (c2_tx_tid == TID_W'(i));

      assign active_vec[i] = active;
      assign expire_vec[i] = active && !fired && !rsp_hit && (timer == TIMER_LAST);

      // New request wins over a same-cycle response
      always_ff @(posedge clk) begin
         if (reset) begin
            active <= 1'b0;
            fired  <= 1'b0;
         end else if (req_hit) begin
            active <= 1'b1;
            fired  <= 1'b0;
         end else if (rsp_hit) begin
            active <= 1'b0;
            fired  <= 1'b0;
         end else if (expire_vec[i]) begin
            fired <= 1'b1;
         end
      end

      // Counts only while waiting, frozen once fired
      always_ff @(posedge clk) begin
         if (req_hit) begin
            timer <= '0;
         end else if (active && !fired) begin
            timer <= timer + 1'b1;
         end
      end
   end

   always_comb begin
      err_next = '0;
      // Same-cycle request to this TID does not count
      err_next[sniff_pkg::ERR_MMIO_UNSOLICITED] = c2_tx_mmio_rd_valid && !active_vec[c2_tx_tid];
      err_next[sniff_pkg::ERR_MMIO_TIMEOUT]     = |expire_vec;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         err <= '0;
      end else begin
         err <= err_next;
      end
   end

endmodule

// File: verilog/ccip_sniffer.sv
/*
 * CCI-P request checker top level.
 * Observes only, never stalls or alters traffic.
 * err bits are one-cycle pulses, one cycle after the offending sample.
 * err stays low during reset and in the first cycle after it.
 */

`include "sniff_params.svh"

module ccip_sniffer (
   input  logic                          clk,
   input  logic                          reset,
   // Read requests
   input  logic                          c0_tx_valid,
   input  ccip_hdr_pkg::c0_req_hdr_t     c0_tx_hdr,
   // Write requests
   input  logic                          c1_tx_valid,
   input  ccip_hdr_pkg::c1_req_hdr_t     c1_tx_hdr,
   // Port full levels
   input  logic                          c0_tx_full,
   input  logic                          c1_tx_full,
   // MMIO read response from the accelerator
   input  logic                          c2_tx_mmio_rd_valid,
   input  logic [`SNIFF_TID_WIDTH-1:0]   c2_tx_tid,
   // MMIO read request to the accelerator
   input  logic                          c0_rx_mmio_rd_valid,
   input  ccip_hdr_pkg::mmio_req_hdr_t   c0_rx_hdr,
   output sniff_pkg::err_vec_t           err
);

   sniff_pkg::err_vec_t tx_err;
   sniff_pkg::err_vec_t wr_err;
   sniff_pkg::err_vec_t mmio_err;

   // Type, length, read alignment and overflow
   tx_request_check tx_check_i (
      .clk         (clk),
      .reset       (reset),
      .c0_tx_valid (c0_tx_valid),
      .c0_tx_hdr   (c0_tx_hdr),
      .c0_tx_full  (c0_tx_full),
      .c1_tx_valid (c1_tx_valid),
      .c1_tx_hdr   (c1_tx_hdr),
      .c1_tx_full  (c1_tx_full),
      .err         (tx_err)
   );

   // Multi-line write beat sequence
   mcl_write_check mcl_write_i (
      .clk         (clk),
      .reset       (reset),
      .c1_tx_valid (c1_tx_valid),
      .c1_tx_hdr   (c1_tx_hdr),
      .err         (wr_err)
   );

   // MMIO read request/response pairing by TID
   mmio_tracker mmio_tracker_i (
      .clk                 (clk),
      .reset               (reset),
      .c0_rx_mmio_rd_valid (c0_rx_mmio_rd_valid),
      .c0_rx_hdr           (c0_rx_hdr),
      .c2_tx_mmio_rd_valid (c2_tx_mmio_rd_valid),
      .c2_tx_tid           (c2_tx_tid),
      .err                 (mmio_err)
   );

   // Checkers own disjoint bits, already registered
   assign err = tx_err | wr_err | mmio_err;

endmodule

// File: verification/ccip_sniffer_asserts.sv
/*
 * Concurrent checks bound into the checker top level.
 * Covers reset behavior and pulse shape of a few err bits.
 */

module ccip_sniffer_asserts (
   input logic                 clk,
   input logic                 reset,
   input logic                 c0_tx_valid,
   input logic                 c1_tx_valid,
   input sniff_pkg::err_vec_t  err
);
   timeunit 1ns;
   timeprecision 100ps;

   // Held low through reset and one cycle after
   reset_quiet: assert property (@(posedge clk) $past(reset) |-> err == '0)
      else $error("err not zero in or right after reset");

   // Back-to-back pulses need back-to-back requests
   c0_type_pulse: assert property (@(posedge clk) disable iff (reset)
      (err[sniff_pkg::ERR_C0_TYPE] && $past(err[sniff_pkg::ERR_C0_TYPE]))
      |-> ($past(c0_tx_valid) && $past(c0_tx_valid, 2)))
      else $error("C0 type error held without repeated request");

   c1_type_pulse: assert property (@(posedge clk) disable iff (reset)
      (err[sniff_pkg::ERR_C1_TYPE] && $past(err[sniff_pkg::ERR_C1_TYPE]))
      |-> ($past(c1_tx_valid) && $past(c1_tx_valid, 2)))
      else $error("C1 type error held without repeated request");

   // Length three only reported for a real read
   c0_len3_cause: assert property (@(posedge clk) disable iff (reset)
      err[sniff_pkg::ERR_C0_LEN3] |-> $past(c0_tx_valid))
      else $error("C0 length error without a C0 request");

endmodule

bind ccip_sniffer ccip_sniffer_asserts asserts_i (
   .clk         (clk),
   .reset       (reset),
   .c0_tx_valid (c0_tx_valid),
   .c1_tx_valid (c1_tx_valid),
   .err         (err)
);

// File: verification/ccip_sniffer_tb.sv
/*
 * Self-checking testbench for the CCI-P request checker.
 * Expected err comes from a model of the burst and TID state, one cycle late.
 * Inputs change 1 ns after the rising edge, err is compared on the falling edge.
 * Stops at the first mismatch.
 */

`include "sniff_params.svh"

module ccip_sniffer_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int DEPTH = 2 ** `SNIFF_TID_WIDTH;

   logic                              clk = 1'b0;
   logic                              reset;
   logic                              c0_tx_valid;
   ccip_hdr_pkg::c0_req_hdr_t         c0_tx_hdr;
   logic                              c1_tx_valid;
   ccip_hdr_pkg::c1_req_hdr_t         c1_tx_hdr;
   logic                              c0_tx_full;
   logic                              c1_tx_full;
   logic                              c2_tx_mmio_rd_valid;
   logic [`SNIFF_TID_WIDTH-1:0]       c2_tx_tid;
   logic                              c0_rx_mmio_rd_valid;
   ccip_hdr_pkg::mmio_req_hdr_t       c0_rx_hdr;
   sniff_pkg::err_vec_t               err;

   // Reference model state
   sniff_pkg::err_vec_t               exp_q;
   logic                              checking = 1'b0;
   int                                wr_left;
   int                                wr_offset;
   logic [`SNIFF_ADDR_WIDTH-1:0]      wr_base;
   logic [1:0]                        wr_vc;
   logic [`SNIFF_MDATA_WIDTH-1:0]     wr_mdata;
   logic                              tid_active [DEPTH];
   int                                tid_age [DEPTH];
   integer                            seed = 85896;
   int                                n;
   logic [`SNIFF_ADDR_WIDTH-1:0]      a;
   logic [`SNIFF_TID_WIDTH-1:0]       t;

   ccip_sniffer dut_i (.*);

   always #5 clk = ~clk;

   // Expected err for the inputs sampled at this edge, advances the model
   function automatic sniff_pkg::err_vec_t predict_err();
      sniff_pkg::err_vec_t e;
      logic                beat;
      logic                rsp;
      logic                req;
      e = '0;
      if (c0_tx_valid) begin
         e[sniff_pkg::ERR_C0_TYPE] = !(c0_tx_hdr.req_type inside
            {ccip_hdr_pkg::REQ_RDLINE_I, ccip_hdr_pkg::REQ_RDLINE_S});
         e[sniff_pkg::ERR_C0_LEN3] = (c0_tx_hdr.cl_len == ccip_hdr_pkg::CL_LEN_3);
         e[sniff_pkg::ERR_C0_ALIGN] =
            (c0_tx_hdr.cl_len == ccip_hdr_pkg::CL_LEN_2 && c0_tx_hdr.address[0]) ||
            (c0_tx_hdr.cl_len == ccip_hdr_pkg::CL_LEN_4 && c0_tx_hdr.address[1:0] != 2'b00);
         e[sniff_pkg::WARN_C0_OVERFLOW] = c0_tx_full;
      end
      if (c1_tx_valid) begin
         e[sniff_pkg::ERR_C1_TYPE] = !(c1_tx_hdr.req_type inside
            {ccip_hdr_pkg::REQ_WRLINE_I, ccip_hdr_pkg::REQ_WRLINE_M, ccip_hdr_pkg::REQ_WRFENCE});
         e[sniff_pkg::WARN_C1_OVERFLOW] = c1_tx_full;
      end
      // Write bursts, fences are not beats
      beat = c1_tx_valid && (c1_tx_hdr.req_type inside
         {ccip_hdr_pkg::REQ_WRLINE_I, ccip_hdr_pkg::REQ_WRLINE_M});
      if (beat && wr_left == 0) begin
         e[sniff_pkg::ERR_C1_SOP] = !c1_tx_hdr.sop;
         e[sniff_pkg::ERR_C1_LEN3] = (c1_tx_hdr.cl_len == ccip_hdr_pkg::CL_LEN_3);
         if (c1_tx_hdr.cl_len == ccip_hdr_pkg::CL_LEN_2) begin
            e[sniff_pkg::ERR_C1_ALIGN] = c1_tx_hdr.address[0];
            wr_left = 1;
         end else if (c1_tx_hdr.cl_len == ccip_hdr_pkg::CL_LEN_4) begin
            e[sniff_pkg::ERR_C1_ALIGN] = (c1_tx_hdr.address[1:0] != 2'b00);
            wr_left = 3;
         end
         wr_offset = 1;
         wr_base   = c1_tx_hdr.address;
         wr_vc     = c1_tx_hdr.vc;
         wr_mdata  = c1_tx_hdr.mdata;
      end else if (beat) begin
         e[sniff_pkg::ERR_C1_SOP]    = c1_tx_hdr.sop;
         e[sniff_pkg::ERR_C1_ADDR]   = (c1_tx_hdr.address != wr_base + wr_offset);
         e[sniff_pkg::ERR_C1_VC]     = (c1_tx_hdr.vc != wr_vc);
         e[sniff_pkg::WARN_C1_MDATA] = (c1_tx_hdr.mdata != wr_mdata);
         wr_offset++;
         wr_left--;
      end
      // MMIO, activity seen before this edge's updates
      e[sniff_pkg::ERR_MMIO_UNSOLICITED] = c2_tx_mmio_rd_valid && !tid_active[c2_tx_tid];
      for (int i = 0; i < DEPTH; i++) begin
         req = c0_rx_mmio_rd_valid && (c0_rx_hdr.tid == i);
         rsp = c2_tx_mmio_rd_valid && (c2_tx_tid == i);
         // Edges since the request edge, passes the limit only once
         if (tid_active[i]) begin
            tid_age[i]++;
         end
         if (tid_active[i] && !rsp && tid_age[i] == `SNIFF_MMIO_TIMEOUT) begin
            e[sniff_pkg::ERR_MMIO_TIMEOUT] = 1'b1;
         end
         if (req) begin
            tid_active[i] = 1'b1;
            tid_age[i]    = 0;
         end else if (rsp) begin
            tid_active[i] = 1'b0;
         end
      end
      return e;
   endfunction

   always @(posedge clk) begin
      if (reset) begin
         wr_left  = 0;
         checking <= 1'b1;
         for (int i = 0; i < DEPTH; i++) begin
            tid_active[i] = 1'b0;
         end
         exp_q <= '0;
      end else begin
         exp_q <= predict_err();
      end
   end

   // Compare away from the edge
   always @(negedge clk) begin
      if (checking) begin
         assert (err === exp_q)
         else begin
            $display("FAIL %0t ns err got %h expected %h", $time, err, exp_q);
            $display("Errors found");
            $fatal(1);
         end
      end
   end

   // Next cycle, all strobes back low
   task automatic step();
      @(posedge clk);
      #1;
      c0_tx_valid         = 1'b0;
      c1_tx_valid         = 1'b0;
      c0_tx_full          = 1'b0;
      c1_tx_full          = 1'b0;
      c2_tx_mmio_rd_valid = 1'b0;
      c0_rx_mmio_rd_valid = 1'b0;
   endtask

   task automatic send_read(input ccip_hdr_pkg::req_type_e ty, input ccip_hdr_pkg::cl_len_e len,
                            input logic [`SNIFF_ADDR_WIDTH-1:0] addr, input logic full);
      step();
      c0_tx_valid = 1'b1;
      c0_tx_full  = full;
      c0_tx_hdr   = '{vc: ccip_hdr_pkg::VC_VA, cl_len: len, req_type: ty, address: addr,
                      mdata: 16'($random(seed))};
   endtask

   task automatic send_write(input ccip_hdr_pkg::req_type_e ty, input ccip_hdr_pkg::cl_len_e len,
                             input logic sop, input ccip_hdr_pkg::vc_e vc,
                             input logic [`SNIFF_ADDR_WIDTH-1:0] addr,
                             input logic [15:0] md, input logic full);
      step();
      c1_tx_valid = 1'b1;
      c1_tx_full  = full;
      c1_tx_hdr   = '{vc: vc, sop: sop, cl_len: len, req_type: ty, address: addr, mdata: md};
   endtask

   // Well-formed burst, beats back to back
   task automatic write_burst(input ccip_hdr_pkg::cl_len_e len,
                              input logic [`SNIFF_ADDR_WIDTH-1:0] addr);
      for (int b = 0; b <= int'(len); b++) begin
         send_write(ccip_hdr_pkg::REQ_WRLINE_I, len, b == 0, ccip_hdr_pkg::VC_VL0,
                    addr + b, 16'h1234, 1'b0);
      end
   endtask

   task automatic mmio(input logic is_req, input logic [`SNIFF_TID_WIDTH-1:0] tid);
      step();
      c0_rx_mmio_rd_valid = is_req;
      c2_tx_mmio_rd_valid = !is_req;
      c0_rx_hdr.tid       = tid;
      c2_tx_tid           = tid;
   endtask

   initial begin
      reset = 1'b1;
      c0_tx_valid = 1'b0;
      c1_tx_valid = 1'b0;
      c0_tx_full = 1'b0;
      c1_tx_full = 1'b0;
      c0_tx_hdr = '0;
      c1_tx_hdr = '0;
      c2_tx_mmio_rd_valid = 1'b0;
      c2_tx_tid = '0;
      c0_rx_mmio_rd_valid = 1'b0;
      c0_rx_hdr = '0;
      repeat (5) @(posedge clk);
      #1 reset = 1'b0;
      a = {$random(seed), $random(seed)} & ~42'h3;
      // Request types
      send_read(ccip_hdr_pkg::REQ_RDLINE_I, ccip_hdr_pkg::CL_LEN_1, a, 1'b0);
      send_read(ccip_hdr_pkg::REQ_RDLINE_S, ccip_hdr_pkg::CL_LEN_1, a, 1'b0);
      send_read(ccip_hdr_pkg::REQ_WRLINE_I, ccip_hdr_pkg::CL_LEN_1, a, 1'b0);
      send_read(ccip_hdr_pkg::req_type_e'(4'hf), ccip_hdr_pkg::CL_LEN_1, a, 1'b0);
      send_write(ccip_hdr_pkg::REQ_WRFENCE, ccip_hdr_pkg::CL_LEN_1, 1'b1,
                 ccip_hdr_pkg::VC_VA, a, 16'h0, 1'b0);
      send_write(ccip_hdr_pkg::REQ_RDLINE_I, ccip_hdr_pkg::CL_LEN_1, 1'b1,
                 ccip_hdr_pkg::VC_VA, a, 16'h0, 1'b0);
      send_write(ccip_hdr_pkg::req_type_e'(4'h0), ccip_hdr_pkg::CL_LEN_1, 1'b1,
                 ccip_hdr_pkg::VC_VA, a, 16'h0, 1'b0);
      // Read length and alignment
      send_read(ccip_hdr_pkg::REQ_RDLINE_I, ccip_hdr_pkg::CL_LEN_3, a, 1'b0);
      send_read(ccip_hdr_pkg::REQ_RDLINE_I, ccip_hdr_pkg::CL_LEN_2, a + 1, 1'b0);
      send_read(ccip_hdr_pkg::REQ_RDLINE_S, ccip_hdr_pkg::CL_LEN_4, a + 2, 1'b0);
      send_read(ccip_hdr_pkg::REQ_RDLINE_S, ccip_hdr_pkg::CL_LEN_4, a, 1'b0);
      // Same on C1 first beats
      send_write(ccip_hdr_pkg::REQ_WRLINE_M, ccip_hdr_pkg::CL_LEN_3, 1'b1,
                 ccip_hdr_pkg::VC_VA, a, 16'h0, 1'b0);
      write_burst(ccip_hdr_pkg::CL_LEN_2, a + 1);
      write_burst(ccip_hdr_pkg::CL_LEN_4, a + 2);
      // Clean bursts, then each fault mid-burst
      write_burst(ccip_hdr_pkg::CL_LEN_4, a);
      write_burst(ccip_hdr_pkg::CL_LEN_2, a + 4);
      send_write(ccip_hdr_pkg::REQ_WRLINE_I, ccip_hdr_pkg::CL_LEN_1, 1'b0,
                 ccip_hdr_pkg::VC_VA, a, 16'h5, 1'b0);
      for (int f = 0; f < 4; f++) begin
         send_write(ccip_hdr_pkg::REQ_WRLINE_I, ccip_hdr_pkg::CL_LEN_4, 1'b1,
                    ccip_hdr_pkg::VC_VL0, a, 16'h77, 1'b0);
         send_write(ccip_hdr_pkg::REQ_WRLINE_I, ccip_hdr_pkg::CL_LEN_4, f == 0,
                    f == 2 ? ccip_hdr_pkg::VC_VH0 : ccip_hdr_pkg::VC_VL0,
                    f == 1 ? a + 2 : a + 1, f == 3 ? 16'h78 : 16'h77, 1'b0);
         write_burst(ccip_hdr_pkg::CL_LEN_2, a + 8);
      end
      // Fence inside a burst is not a beat
      send_write(ccip_hdr_pkg::REQ_WRLINE_I, ccip_hdr_pkg::CL_LEN_2, 1'b1,
                 ccip_hdr_pkg::VC_VA, a, 16'h1, 1'b0);
      send_write(ccip_hdr_pkg::REQ_WRFENCE, ccip_hdr_pkg::CL_LEN_1, 1'b0,
                 ccip_hdr_pkg::VC_VA, a, 16'h1, 1'b0);
      send_write(ccip_hdr_pkg::REQ_WRLINE_I, ccip_hdr_pkg::CL_LEN_2, 1'b0,
                 ccip_hdr_pkg::VC_VA, a + 1, 16'h1, 1'b0);
      // Overflow warnings
      send_read(ccip_hdr_pkg::REQ_RDLINE_I, ccip_hdr_pkg::CL_LEN_1, a, 1'b1);
      send_write(ccip_hdr_pkg::REQ_WRLINE_I, ccip_hdr_pkg::CL_LEN_1, 1'b1,
                 ccip_hdr_pkg::VC_VA, a, 16'h0, 1'b1);
      // MMIO, unsolicited first while every TID is idle
      t = 9'($random(seed));
      mmio(1'b0, t);
      mmio(1'b1, t);
      repeat (10) step();
      mmio(1'b0, t);
      mmio(1'b1, t + 1);
      mmio(1'b0, t);
      // Unanswered request, edges counted from its sampling edge
      n = 0;
      while (!err[sniff_pkg::ERR_MMIO_TIMEOUT] && n < 2 * `SNIFF_MMIO_TIMEOUT) begin
         step();
         n++;
      end
      if (!err[sniff_pkg::ERR_MMIO_TIMEOUT] || n != `SNIFF_MMIO_TIMEOUT) begin
         $display("MMIO timeout pulse missing or late, %0d edges after the request", n);
         $display("Errors found");
         $fatal(1);
      end else begin
         repeat (50) step();
         $display("No errors");
         $finish;
      end
   end

endmodule

// File: flist.f
+incdir+common
common/ccip_hdr_pkg.sv
common/sniff_pkg.sv
verilog/tx_request_check.sv
mcl_write/mcl_write_check.sv
mmio_tracker/mmio_tracker.sv
verilog/ccip_sniffer.sv
verification/ccip_sniffer_asserts.sv
verification/ccip_sniffer_tb.sv

// File: Bender.yml
package:
  name: ccip_sniffer

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ccip_hdr_pkg.sv
      - common/sniff_pkg.sv
      - verilog/tx_request_check.sv
      - mcl_write/mcl_write_check.sv
      - mmio_tracker/mmio_tracker.sv
      - verilog/ccip_sniffer.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/ccip_sniffer_asserts.sv
      - verification/ccip_sniffer_tb.sv
